/* build.f */
verilog/arcade_glue_pkg.sv
verilog/rom_loader.sv
verilog/reset_gen.sv
verilog/pause_ctrl.sv
verilog/input_mapper.sv
verilog/video_out.sv
verilog/arcade_glue_top.sv
verification/tb_arcade_glue.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator and run the arcade glue testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
	-f build.f --top-module tb_arcade_glue -o tb_sim

out=$(./obj_dir/tb_sim || true)
echo "$out"
echo "$out" | grep -q "^TEST PASSED$"

/* verification/tb_arcade_glue.sv */
/*
 * Testbench for the arcade board glue top level
 * Download, reset, pause and dim, video and input mapping checks
 */
`default_nettype none

module tb_arcade_glue;
	timeunit 1ns;
	timeprecision 1ps;
	import arcade_glue_pkg::*;

	localparam int RESET_HOLD = 20;
	localparam int DIM_CYCLES = 50;
	localparam int N_ROM_WR   = 40;
	localparam int N_MAP      = 200;
	localparam int WATCHDOG_CYCLES = 4 * N_ROM_WR + 4 * (RESET_HOLD + 12)
	                               + 2 * (DIM_CYCLES + 20) + 3 * 8 * 4 + 2 * N_MAP + 500;

	logic clk_sys = 1'b0;
	logic rst;
	logic ioctl_download, ioctl_wr, hs_access, osd_status, user_button;
	logic [7:0] ioctl_index, ioctl_dout;
	dl_addr_t ioctl_addr;
	osd_settings_t settings;
	joy_word_t usb_joy1, usb_joy2, db_joy1, db_joy2;
	video_t video_in, video_o, exp_video;
	logic [7:0] core_mod, dip_sw0, dip_sw1;
	logic snd_rom_we, port1_req, port2_req, rom_loaded, game_reset;
	player_ctrl_t p1, p2;
	cabinet_ctrl_t cab;
	logic user_osd, paused, dim, rotate_ccw;
	logic [12:0] video_arx, video_ary;

	// Expected state kept by the testbench
	logic [7:0] exp_core_mod;
	logic exp_loaded;
	logic checks_on;

	arcade_glue_top #(
		.RESET_HOLD (RESET_HOLD),
		.DIM_CYCLES (DIM_CYCLES)
	) u_arcade_glue_top (
		.clk_sys (clk_sys), .rst (rst),
		.ioctl_download (ioctl_download), .ioctl_wr (ioctl_wr),
		.ioctl_index (ioctl_index), .ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout),
		.settings (settings), .user_button (user_button),
		.osd_status (osd_status), .hs_access (hs_access),
		.usb_joy1 (usb_joy1), .usb_joy2 (usb_joy2), .db_joy1 (db_joy1), .db_joy2 (db_joy2),
		.video_in (video_in), .core_mod (core_mod), .dip_sw0 (dip_sw0), .dip_sw1 (dip_sw1),
		.snd_rom_we (snd_rom_we), .port1_req (port1_req), .port2_req (port2_req),
		.rom_loaded (rom_loaded), .game_reset (game_reset),
		.p1 (p1), .p2 (p2), .cab (cab), .user_osd (user_osd),
		.paused (paused), .dim (dim), .video_o (video_o),
		.video_arx (video_arx), .video_ary (video_ary), .rotate_ccw (rotate_ccw)
	);

	always #20 clk_sys = ~clk_sys;

	// ========================================
	// Reporting
	// ========================================
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
			stop_run("value mismatch");
		end
	endtask

	// ========================================
	// Reference functions
	// ========================================
	function automatic logic snd_we_rule(input logic dl, input logic wr,
	                                     input logic [7:0] idx, input dl_addr_t a);
		return dl && wr && (idx == 8'd0) && (a >= 25'h20000) && (a < 25'h30000);
	endfunction

	// USB word bits are 0 right, 1 left, 2 down, 3 up, 4/5 fire, 6/7 start, 8 coin, 9 pause
	function automatic joy_word_t db_as_usb(input joy_word_t d, input logic second);
		logic coin;
		coin = d[11] | (d[10] & d[5]);
		if (second)
			return {7'd0, coin, d[9], d[10], d[5:0]};
		return {7'd0, coin, d[10], d[9], d[5:0]};
	endfunction

	function automatic logic [5:0] player_bits(input joy_word_t w);
		return {w[3], w[2], w[1], w[0], w[4], w[5]};
	endfunction

	// Packed as {p1, p2, cab, user_osd}
	function automatic logic [17:0] mapped_controls(input osd_settings_t s,
	                                                input joy_word_t u1,
	                                                input joy_word_t u2,
	                                                input joy_word_t d1,
	                                                input joy_word_t d2);
		logic use1;
		logic use2;
		joy_word_t j1;
		joy_word_t j2;
		use1 = s.joy_mode != 2'd0;
		use2 = use1 && s.two_players;
		j1 = use1 ? db_as_usb(d1, 1'b0) : u1;
		j2 = use2 ? db_as_usb(d2, 1'b1) : (use1 ? u1 : u2);
		return {player_bits(j1), player_bits(j2), j1[8], j2[8], j1[6] | j2[6],
		        j1[7] | j2[7], j1[9] | j2[9], use1 & d1[10] & d1[6]};
	endfunction

	// Packed as {arx, ary, rotate_ccw}
	function automatic logic [26:0] aspect_rule(input osd_settings_t s, input logic [7:0] v);
		logic wide;
		wide = s.orient_horz || ((v != 8'h06) && (v != 8'h0B));
		if (s.aspect == 2'd0)
			return {wide ? 13'd4 : 13'd3, wide ? 13'd3 : 13'd4, v == 8'h0B};
		return {13'(s.aspect) - 13'd1, 13'd0, v == 8'h0B};
	endfunction

	function automatic video_t video_after_dim(input video_t v, input logic dimmed);
		video_t o;
		o = v;
		if (dimmed)
			o.rgb = {v.rgb.r >> 1, v.rgb.g >> 1, v.rgb.b >> 1};
		return o;
	endfunction

	// ========================================
	// Compare process
	// ========================================
	always @(posedge clk_sys) begin
		exp_video = video_after_dim(video_in, dim);
	end

	always @(negedge clk_sys) begin
		if (checks_on) begin
			check("snd_rom_we", snd_we_rule(ioctl_download, ioctl_wr, ioctl_index, ioctl_addr),
			      snd_rom_we);
			check("p1/p2/cab/user_osd",
			      mapped_controls(settings, usb_joy1, usb_joy2, db_joy1, db_joy2),
			      {p1, p2, cab, user_osd});
			check("arx/ary/rotate_ccw", aspect_rule(settings, exp_core_mod),
			      {video_arx, video_ary, rotate_ccw});
			check("video_o", exp_video, video_o);
			check("rom_loaded", exp_loaded, rom_loaded);
			if (!exp_loaded)
				check("game_reset", 1'b1, game_reset);
		end
	end

	// Random video every cycle
	always @(posedge clk_sys) begin
		if (!rst)
			video_in <= video_t'($urandom);
	end

	// ========================================
	// Stimulus tasks
	// ========================================
	task automatic dl_write(input logic [7:0] idx, input dl_addr_t a, input logic [7:0] d);
		@(posedge clk_sys);
		ioctl_wr    <= 1'b1;
		ioctl_index <= idx;
		ioctl_addr  <= a;
		ioctl_dout  <= d;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	task automatic measure_release();
		int n;
		n = 0;
		while (game_reset && n < RESET_HOLD + 10) begin
			@(negedge clk_sys);
			n++;
		end
		if (n < RESET_HOLD || n > RESET_HOLD + 2)
			stop_run($sformatf("game_reset released after %0d cycles, out of window", n));
	endtask

	task automatic pulse_cause(input logic use_button);
		@(posedge clk_sys);
		if (use_button)
			user_button <= 1'b1;
		else
			settings.reset_req <= 1'b1;
		@(posedge clk_sys);
		user_button        <= 1'b0;
		settings.reset_req <= 1'b0;
		@(negedge clk_sys);
		check("game_reset", 1'b1, game_reset);
		measure_release();
	endtask

	task automatic press_pause();
		@(posedge clk_sys);
		usb_joy1 <= 16'h0200;
		@(posedge clk_sys);
		usb_joy1 <= 16'h0000;
		@(negedge clk_sys);
	endtask

	task automatic download_routing();
		int p1_cnt;
		int p2_cnt;
		logic [7:0] d0;
		logic [7:0] d1;
		dl_addr_t a;
		p1_cnt = 0;
		p2_cnt = 0;
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= 8'd0;
		for (int i = 0; i < N_ROM_WR; i++) begin
			a = dl_addr_t'($urandom % 32'h40000);
			dl_write(8'd0, a, 8'($urandom));
			p1_cnt++;
			if (a >= 25'h30000)
				p2_cnt++;
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		// Loaded flag comes up two cycles after the download ends
		repeat (2) @(posedge clk_sys);
		exp_loaded = 1'b1;
		@(negedge clk_sys);
		measure_release();
		check("port1_req", 1'(p1_cnt), port1_req);
		check("port2_req", 1'(p2_cnt), port2_req);
		// Bytes above 1 go into the DIP bank but are not exported
		d0 = 8'($urandom);
		d1 = 8'($urandom);
		for (int i = 0; i < 8; i++)
			dl_write(8'd254, dl_addr_t'(i), (i == 0) ? d0 : (i == 1) ? d1 : 8'($urandom));
		@(negedge clk_sys);
		check("dip_sw0", d0, dip_sw0);
		check("dip_sw1", d1, dip_sw1);
	endtask

	task automatic set_variant(input logic [7:0] v);
		dl_write(8'd1, '0, v);
		exp_core_mod = v;
		@(negedge clk_sys);
		check("core_mod", v, core_mod);
	endtask

	task automatic pause_and_dim();
		int n;
		press_pause();
		check("paused", 1'b1, paused);
		n = 0;
		while (!dim && n < DIM_CYCLES + 5) begin
			@(negedge clk_sys);
			n++;
		end
		if (n < DIM_CYCLES || n > DIM_CYCLES + 1)
			stop_run($sformatf("dim rose after %0d paused cycles, out of window", n));
		repeat (4) @(negedge clk_sys);
		press_pause();
		check("paused", 1'b0, paused);
		@(negedge clk_sys);
		check("dim", 1'b0, dim);
		// Menu and high-score sources
		@(posedge clk_sys);
		osd_status <= 1'b1;
		@(negedge clk_sys);
		check("paused", 1'b1, paused);
		@(posedge clk_sys);
		settings.pause_osd_off <= 1'b1;
		@(negedge clk_sys);
		check("paused", 1'b0, paused);
		@(posedge clk_sys);
		hs_access <= 1'b1;
		@(negedge clk_sys);
		check("paused", 1'b1, paused);
		@(posedge clk_sys);
		hs_access              <= 1'b0;
		osd_status             <= 1'b0;
		settings.pause_osd_off <= 1'b0;
		@(negedge clk_sys);
		check("paused", 1'b0, paused);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		void'($urandom(32'h497));
		rst = 1'b1;
		{ioctl_download, ioctl_wr, hs_access, osd_status, user_button} = '0;
		ioctl_index = '0;
		ioctl_dout  = '0;
		ioctl_addr  = '0;
		settings    = '0;
		{usb_joy1, usb_joy2, db_joy1, db_joy2} = '0;
		video_in     = '0;
		exp_core_mod = '0;
		exp_loaded   = 1'b0;
		checks_on    = 1'b0;
		repeat (2) @(posedge clk_sys);
		rst <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		checks_on = 1'b1;

		download_routing();
		pulse_cause(1'b0);
		pulse_cause(1'b1);
		pause_and_dim();

		for (int k = 0; k < 3; k++) begin
			set_variant((k == 0) ? 8'h06 : (k == 1) ? 8'h0B : 8'h20 + 8'($urandom % 64));
			for (int m = 0; m < 8; m++) begin
				@(posedge clk_sys);
				settings.aspect      <= 2'(m);
				settings.orient_horz <= m[2];
				@(negedge clk_sys);
			end
		end

		for (int i = 0; i < N_MAP; i++) begin
			@(posedge clk_sys);
			usb_joy1             <= joy_word_t'($urandom);
			usb_joy2             <= joy_word_t'($urandom);
			db_joy1              <= joy_word_t'($urandom);
			db_joy2              <= joy_word_t'($urandom);
			settings.joy_mode    <= 2'(i % 4);
			settings.two_players <= i[2];
		end
		@(negedge clk_sys);
		$display("TEST PASSED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		stop_run("watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

/* verilog/arcade_glue_top.sv */
/*
 * Arcade board glue top level
 * Download decode, reset, pause, input mapping and video output
 */
`default_nettype none

module arcade_glue_top #(
	parameter int RESET_HOLD = 65535,
	parameter int DIM_CYCLES = 240000000
) (
	input  logic                           clk_sys,
	input  logic                           rst,
	// Download stream
	input  logic                           ioctl_download,
	input  logic                           ioctl_wr,
	input  logic [7:0]                     ioctl_index,
	input  arcade_glue_pkg::dl_addr_t      ioctl_addr,
	input  logic [7:0]                     ioctl_dout,
	// Menu and framework
	input  arcade_glue_pkg::osd_settings_t settings,
	input  logic                           user_button,
	input  logic                           osd_status,
	input  logic                           hs_access,
	// Joysticks
	input  arcade_glue_pkg::joy_word_t     usb_joy1,
	input  arcade_glue_pkg::joy_word_t     usb_joy2,
	input  arcade_glue_pkg::joy_word_t     db_joy1,
	input  arcade_glue_pkg::joy_word_t     db_joy2,
	// Video from the game
	input  arcade_glue_pkg::video_t        video_in,
	// To the game and memories
	output logic [7:0]                     core_mod,
	output logic [7:0]                     dip_sw0,
	output logic [7:0]                     dip_sw1,
	output logic                           snd_rom_we,
	output logic                           port1_req,
	output logic                           port2_req,
	output logic                           rom_loaded,
	output logic                           game_reset,
	output arcade_glue_pkg::player_ctrl_t  p1,
	output arcade_glue_pkg::player_ctrl_t  p2,
	output arcade_glue_pkg::cabinet_ctrl_t cab,
	output logic                           user_osd,
	output logic                           paused,
	output logic                           dim,
	// Video to the scaler
	output arcade_glue_pkg::video_t        video_o,
	output logic [12:0]                    video_arx,
	output logic [12:0]                    video_ary,
	output logic                           rotate_ccw
);

	rom_loader u_rom_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_download   (),
		.rom_loaded     (rom_loaded),
		.core_mod       (core_mod),
		.dip_sw0        (dip_sw0),
		.dip_sw1        (dip_sw1),
		.snd_rom_we     (snd_rom_we),
		.port1_req      (port1_req),
		.port2_req      (port2_req)
	);

	reset_gen #(
		.RESET_HOLD (RESET_HOLD)
	) u_reset_gen (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.reset_req   (settings.reset_req),
		.user_button (user_button),
		.rom_loaded  (rom_loaded),
		.game_reset  (game_reset)
	);

	// Pause button comes from the mapped cabinet controls
	pause_ctrl #(
		.DIM_CYCLES (DIM_CYCLES)
	) u_pause_ctrl (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.pause_btn     (cab.pause_btn),
		.hs_access     (hs_access),
		.osd_status    (osd_status),
		.pause_osd_off (settings.pause_osd_off),
		.paused        (paused),
		.dim           (dim)
	);

	input_mapper u_input_mapper (
		.settings (settings),
		.usb_joy1 (usb_joy1),
		.usb_joy2 (usb_joy2),
		.db_joy1  (db_joy1),
		.db_joy2  (db_joy2),
		.p1       (p1),
		.p2       (p2),
		.cab      (cab),
		.user_osd (user_osd)
	);

	video_out u_video_out (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.video_in   (video_in),
		.dim        (dim),
		.core_mod   (core_mod),
		.settings   (settings),
		.video_o    (video_o),
		.video_arx  (video_arx),
		.video_ary  (video_ary),
		.rotate_ccw (rotate_ccw)
	);

endmodule

`default_nettype wire

/* verilog/video_out.sv */
/*
 * Video output stage
 * Registered video with dimming, rotation decode, aspect ratio
 */
`default_nettype none

module video_out (
	input  logic                           clk_sys,
	input  logic                           rst,
	input  arcade_glue_pkg::video_t        video_in,
	input  logic                           dim,
	input  logic [7:0]                     core_mod,
	input  arcade_glue_pkg::osd_settings_t settings,
	output arcade_glue_pkg::video_t        video_o,
	output logic [12:0]                    video_arx,
	output logic [12:0]                    video_ary,
	output logic                           rotate_ccw
);
	import arcade_glue_pkg::*;

	rgb_t rgb_dimmed;
	logic landscape;
	logic wide;

	assign rgb_dimmed.r = {1'b0, video_in.rgb.r[3:1]};
	assign rgb_dimmed.g = {1'b0, video_in.rgb.g[3:1]};
	assign rgb_dimmed.b = {1'b0, video_in.rgb.b[3:1]};

	always_ff @(posedge clk_sys) begin
		video_o.rgb <= dim ? rgb_dimmed : video_in.rgb;
	end

	// Blank the output until the game drives timing
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			{video_o.hblank, video_o.vblank, video_o.hs, video_o.vs} <= 4'b1100;
		end else begin
			video_o.hblank <= video_in.hblank;
			video_o.vblank <= video_in.vblank;
			video_o.hs     <= video_in.hs;
			video_o.vs     <= video_in.vs;
		end
	end

	// Two titles run on a vertical monitor
	assign landscape  = (core_mod != VARIANT_BATTROAD) && (core_mod != VARIANT_YOUJYUDN);
	assign rotate_ccw = (core_mod == VARIANT_YOUJYUDN);
	assign wide       = settings.orient_horz || landscape;

	assign video_arx = (settings.aspect == 2'd0) ? (wide ? 13'd4 : 13'd3)
	                                             : ({11'd0, settings.aspect} - 13'd1);
	assign video_ary = (settings.aspect == 2'd0) ? (wide ? 13'd3 : 13'd4) : 13'd0;

endmodule

`default_nettype wire

/* verilog/input_mapper.sv */
/*
 * Joystick source selection
 * USB or user-port DB words mapped to player and cabinet controls
 */
`default_nettype none

module input_mapper (
	input  arcade_glue_pkg::osd_settings_t settings,
	input  arcade_glue_pkg::joy_word_t     usb_joy1,
	input  arcade_glue_pkg::joy_word_t     usb_joy2,
	input  arcade_glue_pkg::joy_word_t     db_joy1,
	input  arcade_glue_pkg::joy_word_t     db_joy2,
	output arcade_glue_pkg::player_ctrl_t  p1,
	output arcade_glue_pkg::player_ctrl_t  p2,
	output arcade_glue_pkg::cabinet_ctrl_t cab,
	output logic                           user_osd
);
	import arcade_glue_pkg::*;

	logic      db1_en;
	logic      db2_en;
	joy_word_t joy1;
	joy_word_t joy2;

	// Repack a DB word into the USB layout
	// bit 8 coin, 7 start2, 6 start1, 5..0 fire and directions
	function automatic joy_word_t map_db(input joy_word_t db, input logic swap_start);
		logic coin;
		logic s1;
		logic s2;
		coin = db[11] | (db[10] & db[5]);
		s1   = swap_start ? db[10] : db[9];
		s2   = swap_start ? db[9] : db[10];
		return {7'd0, coin, s2, s1, db[5:0]};
	endfunction

	function automatic player_ctrl_t to_player(input joy_word_t w);
		player_ctrl_t p;
		p.up     = w[3];
		p.down   = w[2];
		p.left   = w[1];
		p.right  = w[0];
		p.fire_a = w[4];
		p.fire_b = w[5];
		return p;
	endfunction

	assign db1_en = settings.joy_mode != 2'd0;
	assign db2_en = db1_en && settings.two_players;

	// With DB port 1 active, USB joystick 1 moves over to player 2
	assign joy1 = db1_en ? map_db(db_joy1, 1'b0) : usb_joy1;
	assign joy2 = db2_en ? map_db(db_joy2, 1'b1) : (db1_en ? usb_joy1 : usb_joy2);

	assign p1 = to_player(joy1);
	assign p2 = to_player(joy2);

	assign cab.coin1     = joy1[8];
	assign cab.coin2     = joy2[8];
	assign cab.start1    = joy1[6] | joy2[6];
	assign cab.start2    = joy1[7] | joy2[7];
	assign cab.pause_btn = joy1[9] | joy2[9];

	// Menu button combo on the first DB pad
	assign user_osd = db1_en && db_joy1[10] && db_joy1[6];

endmodule

`default_nettype wire

/* verilog/pause_ctrl.sv */
/*
 * Pause control
 * Button toggle, high-score and menu pause, dim timer
 */
`default_nettype none

module pause_ctrl #(
	parameter int DIM_CYCLES = 240000000
) (
	input  logic clk_sys,
	input  logic rst,
	input  logic pause_btn,
	input  logic hs_access,
	input  logic osd_status,
	input  logic pause_osd_off,
	output logic paused,
	output logic dim
);

	localparam int TW = $clog2(DIM_CYCLES + 1);

	logic          btn_last;
	logic          pause_toggle;
	logic [TW-1:0] dim_timer;

	// High-score access and an open menu also stop the game
	assign paused = pause_toggle || hs_access || (osd_status && !pause_osd_off);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			btn_last     <= 1'b0;
			pause_toggle <= 1'b0;
		end else begin
			btn_last <= pause_btn;
			if (pause_btn && !btn_last) begin
				pause_toggle <= ~pause_toggle;
			end
		end
	end

	// Saturating count of paused cycles
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dim_timer <= '0;
		end else if (!paused) begin
			dim_timer <= '0;
		end else if (dim_timer != TW'(DIM_CYCLES)) begin
			dim_timer <= dim_timer + 1'b1;
		end
	end

	assign dim = (dim_timer == TW'(DIM_CYCLES));

	// Screen brightens again right after unpausing
	a_dim_clears: assert property (
		@(posedge clk_sys) disable iff (rst)
		!paused |=> !dim
	);

endmodule

`default_nettype wire

/* verilog/reset_gen.sv */
/*
 * Game reset generator
 * Holds the game in reset for a fixed count after the last cause
 */
`default_nettype none

module reset_gen #(
	parameter int RESET_HOLD = 65535
) (
	input  logic clk_sys,
	input  logic rst,
	input  logic reset_req,
	input  logic user_button,
	input  logic rom_loaded,
	output logic game_reset
);

	localparam int CW = $clog2(RESET_HOLD + 1);

	logic          cause;
	logic [CW-1:0] hold_cnt;

	// Any of these keeps the game stopped
	assign cause = reset_req || user_button || !rom_loaded;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hold_cnt   <= CW'(RESET_HOLD);
			game_reset <= 1'b1;
		end else begin
			if (cause) begin
				hold_cnt <= CW'(RESET_HOLD);
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
			game_reset <= cause || (hold_cnt != '0);
		end
	end

	a_reset_follows_cause: assert property (
		@(posedge clk_sys) disable iff (rst)
		cause |=> game_reset
	);

endmodule

`default_nettype wire

/* verilog/rom_loader.sv */
/*
 * ROM download decoder
 * Variant and DIP byte registers, sound ROM write strobe,
 * SDRAM port request toggles and the loaded flag
 */
`default_nettype none

module rom_loader (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  logic [7:0]                ioctl_index,
	input  arcade_glue_pkg::dl_addr_t ioctl_addr,
	input  logic [7:0]                ioctl_dout,
	output logic                      rom_download,
	output logic                      rom_loaded,
	output logic [7:0]                core_mod,
	output logic [7:0]                dip_sw0,
	output logic [7:0]                dip_sw1,
	output logic                      snd_rom_we,
	output logic                      port1_req,
	output logic                      port2_req
);
	import arcade_glue_pkg::*;

	logic       wr_last;
	logic       wr_rise;
	logic       rom_download_d;
	logic       dl_end;
	logic       in_snd_window;
	logic       dip_wr;
	logic [7:0] dip_bank [8];

	// Index and address decode
	assign rom_download  = ioctl_download && (ioctl_index == IDX_ROM);
	assign in_snd_window = (ioctl_addr >= SND_ROM_BASE) && (ioctl_addr < GFX_ROM_BASE);
	assign snd_rom_we    = ioctl_wr && rom_download && in_snd_window;
	assign dip_wr        = ioctl_wr && (ioctl_index == IDX_DIP) && (ioctl_addr[24:3] == '0);
	assign wr_rise       = ioctl_wr && !wr_last;

	// ========================================
	// Variant and DIP registers
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			core_mod <= '0;
			for (int i = 0; i < 8; i++) begin
				dip_bank[i] <= '0;
			end
		end else begin
			if (ioctl_wr && (ioctl_index == IDX_VARIANT)) begin
				core_mod <= ioctl_dout;
			end
			if (dip_wr) begin
				dip_bank[ioctl_addr[2:0]] <= ioctl_dout;
			end
		end
	end

	// Game only reads the first two switch banks
	assign dip_sw0 = dip_bank[0];
	assign dip_sw1 = dip_bank[1];

	// ========================================
	// SDRAM requests and loaded flag
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_last        <= 1'b0;
			port1_req      <= 1'b0;
			port2_req      <= 1'b0;
			rom_download_d <= 1'b0;
			dl_end         <= 1'b0;
			rom_loaded     <= 1'b0;
		end else begin
			wr_last        <= ioctl_wr;
			rom_download_d <= rom_download;
			dl_end         <= rom_download_d && !rom_download;
			if (rom_download && wr_rise) begin
				port1_req <= ~port1_req;
				// Graphics bytes also go to the second port
				if (ioctl_addr >= GFX_ROM_BASE) begin
					port2_req <= ~port2_req;
				end
			end
			if (dl_end) begin
				rom_loaded <= 1'b1;
			end
		end
	end

	// Requests only toggle while a ROM image is streaming in
	a_req_in_download: assert property (
		@(posedge clk_sys) disable iff (rst)
		$changed({port1_req, port2_req}) |-> $past(rom_download)
	);

endmodule

`default_nettype wire

/* verilog/arcade_glue_pkg.sv */
/*
 * Shared types for the arcade board glue logic
 * Menu settings, player and cabinet controls, video word
 * Download indices, ROM windows and variant codes
 */
`default_nettype none

package arcade_glue_pkg;

	// ========================================
	// Menu settings
	// ========================================
	typedef struct packed {
		logic       reset_req;
		logic       orient_horz;
		logic       pause_osd_off;
		logic [1:0] aspect;      // 0 original, 1 full, 2/3 custom
		logic [1:0] joy_mode;    // 0 off, 1 DB9MD, 2/3 DB15
		logic       two_players;
	} osd_settings_t;

	// ========================================
	// Controls
	// ========================================
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
	} player_ctrl_t;

	typedef struct packed {
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
		logic pause_btn;
	} cabinet_ctrl_t;

	typedef logic [15:0] joy_word_t;

	// ========================================
	// Video
	// ========================================
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	typedef struct packed {
		rgb_t rgb;
		logic hblank;
		logic vblank;
		logic hs;
		logic vs;
	} video_t;

	// Download interface
	typedef logic [24:0] dl_addr_t;

	localparam logic [7:0] IDX_ROM     = 8'd0;
	localparam logic [7:0] IDX_VARIANT = 8'd1;
	localparam logic [7:0] IDX_DIP     = 8'd254;

	// Sound ROM sits between these two addresses
	localparam dl_addr_t SND_ROM_BASE = 25'h0020000;
	localparam dl_addr_t GFX_ROM_BASE = 25'h0030000;

	localparam logic [7:0] VARIANT_BATTROAD = 8'h06;
	localparam logic [7:0] VARIANT_YOUJYUDN = 8'h0B;

endpackage

`default_nettype wire
